/* mac_params.svh */
// Block multiply-accumulate parameters.
// Block length and accumulator width shared by packages and RTL.
`ifndef MAC_PARAMS_SVH
`define MAC_PARAMS_SVH

// samples summed per block.
`define MAC_BLOCK_LEN 16

// accumulator width, kept a multiple of 4 for the look-ahead groups.
`define MAC_ACC_WIDTH 12

`endif

/* arithPkg.sv */
// Arithmetic vector types for the block multiply-accumulate unit.
// Operand, product, sample, shift, term and sum widths.
`include "mac_params.svh"

package arithPkg;

  // multiplier operand.
  typedef logic [3:0] operand;

  // full 4x4 product.
  typedef logic [7:0] product;

  // value fed to the scale path, also its scaled result.
  typedef logic [7:0] sample;

  // divide exponent, 0 to 3.
  typedef logic [1:0] shiftSel;

  // product plus scaled value.
  typedef logic [8:0] term;

  typedef logic [`MAC_ACC_WIDTH-1:0] accum;

endpackage

/* blockPkg.sv */
// Block control types for the accumulator.
// Sample counter and accumulator phase.
`include "mac_params.svh"

package blockPkg;

  // counts samples within a block, wraps at the block length.
  typedef logic [$clog2(`MAC_BLOCK_LEN)-1:0] sampleCount;

  // accIdle until the first sample of a block is taken.
  typedef enum logic {accIdle, accRun} accPhase;

endpackage

/* arrayMult4.sv */
// 4x4 unsigned partial-product multiplier.
// Product and its valid are registered on the sample strobe.
`timescale 1ns/1ps

module arrayMult4 (
  input  logic             C,
  input  logic             CLR,
  input  logic             sampleValid,
  input  arithPkg::operand opA,
  input  arithPkg::operand opB,
  output arithPkg::product prodOut,
  output logic             prodValid
);
  import arithPkg::*;

  product pp0;
  product pp1;
  product pp2;
  product pp3;
  product prodNext;

  // each row is opA shifted into place, gated by one bit of opB.
  assign pp0 = {4'b0000, opA} & {8{opB[0]}};
  assign pp1 = {3'b000, opA, 1'b0} & {8{opB[1]}};
  assign pp2 = {2'b00, opA, 2'b00} & {8{opB[2]}};
  assign pp3 = {1'b0, opA, 3'b000} & {8{opB[3]}};

  // 15 * 15 = 225 still fits in 8 bits.
  assign prodNext = pp0 + pp1 + pp2 + pp3;

  always_ff @(posedge C or posedge CLR)
  begin
    if (CLR)
    begin
      prodOut   <= '0;
      prodValid <= 1'b0;
    end
    else
    begin
      prodValid <= sampleValid;
      if (sampleValid)
        prodOut <= prodNext;
    end
  end

endmodule

/* shiftScaler.sv */
// Power-of-two divider with round half up.
// Divides by 1, 2, 4 or 8 and registers the result with its valid.
`timescale 1ns/1ps

module shiftScaler (
  input  logic              C,
  input  logic              CLR,
  input  logic              sampleValid,
  input  arithPkg::sample   scaleIn,
  input  arithPkg::shiftSel scaleShift,
  output arithPkg::sample   scaledOut,
  output logic              scaledValid
);
  import arithPkg::*;

  sample quotient;
  logic  remTop;
  sample scaledNext;

  // quotient is the shifted value, remTop the highest bit shifted out.
  always_comb
  begin
    case (scaleShift)
      2'd1:    quotient = {1'b0, scaleIn[7:1]};
      2'd2:    quotient = {2'b00, scaleIn[7:2]};
      2'd3:    quotient = {3'b000, scaleIn[7:3]};
      default: quotient = scaleIn;
    endcase
    remTop = (scaleShift == 2'd0) ? 1'b0 : scaleIn[3'(scaleShift) - 3'd1];
  end

  // quotient is at most 127 when remTop can be set, so no overflow.
  assign scaledNext = quotient + sample'(remTop);

  always_ff @(posedge C or posedge CLR)
  begin
    if (CLR)
    begin
      scaledOut   <= '0;
      scaledValid <= 1'b0;
    end
    else
    begin
      scaledValid <= sampleValid;
      if (sampleValid)
        scaledOut <= scaledNext;
    end
  end

endmodule

/* claAdder.sv */
// Accumulator-width carry look-ahead adder.
// 4-bit look-ahead groups chained through group generate and propagate.
`timescale 1ns/1ps
`include "mac_params.svh"

module claAdder (
  input  arithPkg::accum a,
  input  arithPkg::accum b,
  output arithPkg::accum sum,
  output logic           carryOut
);
  import arithPkg::*;

  localparam int GROUPS = `MAC_ACC_WIDTH / 4;

  accum              bitGen;
  accum              bitProp;
  accum              bitCarry;
  logic [GROUPS-1:0] grpGen;
  logic [GROUPS-1:0] grpProp;
  logic [GROUPS:0]   grpCarry;

  assign bitGen  = a & b;
  assign bitProp = a ^ b;

  // no carry into the accumulator add.
  assign grpCarry[0] = 1'b0;

  for (genvar k = 0; k < GROUPS; k++)
  begin : gGroup
    logic [3:0] g;
    logic [3:0] p;
    logic       ci;

    assign g  = bitGen[4*k +: 4];
    assign p  = bitProp[4*k +: 4];
    assign ci = grpCarry[k];

    // carries into each bit of the group, all from the group carry in.
    assign bitCarry[4*k]   = ci;
    assign bitCarry[4*k+1] = g[0] | (p[0] & ci);
    assign bitCarry[4*k+2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & ci);
    assign bitCarry[4*k+3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
                           | (p[2] & p[1] & p[0] & ci);

    // group terms for the next level.
    assign grpGen[k]  = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
                      | (p[3] & p[2] & p[1] & g[0]);
    assign grpProp[k] = &p;

    assign grpCarry[k+1] = grpGen[k] | (grpProp[k] & grpCarry[k]);
  end

  assign sum      = bitProp ^ bitCarry;
  assign carryOut = grpCarry[GROUPS];

endmodule

/* blockAccum.sv */
// Block accumulator with asynchronous clear.
// Sums product plus scaled value over a block, then emits sum, overflow and done.
`timescale 1ns/1ps
`include "mac_params.svh"

module blockAccum (
  input  logic             C,
  input  logic             CLR,
  input  logic             prodValid,
  input  arithPkg::product prodOut,
  input  arithPkg::sample  scaledOut,
  output arithPkg::accum   blockSum,
  output logic             blockOverflow,
  output logic             blockDone
);
  import arithPkg::*;
  import blockPkg::*;

  term        termVal;
  accum       termExt;
  accum       accReg;
  accum       accNext;
  logic       addCarry;
  logic       sticky;
  logic       stickyNext;
  logic       lastSample;
  sampleCount count;
  accPhase    phase;

  // scaled value rides alongside the product, same strobe.
  assign termVal = {1'b0, prodOut} + {1'b0, scaledOut};
  assign termExt = accum'(termVal);

  claAdder uAdd (
    .a        (accReg),
    .b        (termExt),
    .sum      (accNext),
    .carryOut (addCarry)
  );

  // a fresh block starts with no carry history.
  assign stickyNext = ((phase == accRun) & sticky) | addCarry;

  assign lastSample = prodValid && (count == sampleCount'(`MAC_BLOCK_LEN - 1));

  always_ff @(posedge C or posedge CLR)
  begin
    if (CLR)
    begin
      accReg        <= '0;
      count         <= '0;
      phase         <= accIdle;
      sticky        <= 1'b0;
      blockSum      <= '0;
      blockOverflow <= 1'b0;
      blockDone     <= 1'b0;
    end
    else
    begin
      blockDone <= 1'b0;
      if (lastSample)
      begin
        // publish the block and start over from zero.
        blockSum      <= accNext;
        blockOverflow <= stickyNext;
        blockDone     <= 1'b1;
        accReg        <= '0;
        count         <= '0;
        phase         <= accIdle;
      end
      else if (prodValid)
      begin
        accReg <= accNext;
        count  <= count + sampleCount'(1);
        phase  <= accRun;
        sticky <= stickyNext;
      end
    end
  end

endmodule

/* macTop.sv */
// Block multiply-accumulate top level.
// Product and scale paths feed the block accumulator.
`timescale 1ns/1ps

module macTop (
  input  logic              C,
  input  logic              CLR,
  input  logic              sampleValid,
  input  arithPkg::operand  opA,
  input  arithPkg::operand  opB,
  input  arithPkg::sample   scaleIn,
  input  arithPkg::shiftSel scaleShift,
  output arithPkg::accum    blockSum,
  output logic              blockOverflow,
  output logic              blockDone
);
  import arithPkg::*;

  product prodOut;
  logic   prodValid;
  sample  scaledOut;
  logic   scaledValid;

  arrayMult4 uMult (
    .C           (C),
    .CLR         (CLR),
    .sampleValid (sampleValid),
    .opA         (opA),
    .opB         (opB),
    .prodOut     (prodOut),
    .prodValid   (prodValid)
  );

  // scaledValid always matches prodValid, so the accumulator ignores it.
  shiftScaler uScale (
    .C           (C),
    .CLR         (CLR),
    .sampleValid (sampleValid),
    .scaleIn     (scaleIn),
    .scaleShift  (scaleShift),
    .scaledOut   (scaledOut),
    .scaledValid (scaledValid)
  );

  blockAccum uAccum (
    .C             (C),
    .CLR           (CLR),
    .prodValid     (prodValid),
    .prodOut       (prodOut),
    .scaledOut     (scaledOut),
    .blockSum      (blockSum),
    .blockOverflow (blockOverflow),
    .blockDone     (blockDone)
  );

endmodule

/* tb_macTop.sv */
// Testbench for the block multiply-accumulate unit.
// Directed block tests checked against a software model of the term rule.
`timescale 1ns/1ps
`include "mac_params.svh"

module tb_macTop;
  import arithPkg::*;

  localparam int DONE_TIMEOUT = 20;
  localparam int ACC_RANGE = 1 << `MAC_ACC_WIDTH;

  logic    C = 1'b0;
  logic    CLR;
  logic    sampleValid;
  operand  opA;
  operand  opB;
  sample   scaleIn;
  shiftSel scaleShift;
  accum    blockSum;
  logic    blockOverflow;
  logic    blockDone;

  int errorCount = 0;
  int testsRun = 0;
  int testsFailed = 0;
  int expTotal = 0;
  integer seed = 19;

  macTop u_dut (
    .C             (C),
    .CLR           (CLR),
    .sampleValid   (sampleValid),
    .opA           (opA),
    .opB           (opB),
    .scaleIn       (scaleIn),
    .scaleShift    (scaleShift),
    .blockSum      (blockSum),
    .blockOverflow (blockOverflow),
    .blockDone     (blockDone)
  );

  always #2 C = ~C;

  // round half up, written as add half then shift.
  function automatic int roundedScale(input int v, input int s);
    int half;
    half = (s == 0) ? 0 : (1 << (s - 1));
    return (v + half) >> s;
  endfunction

  task automatic checkSum(input accum got, input accum exp, input string what);
    if (got !== exp)
    begin
      $display("Mismatch at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkFlag(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      $display("Mismatch at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
      errorCount++;
    end
  endtask

  task automatic driveSample(input operand a, input operand b, input sample v, input shiftSel s);
    @(negedge C);
    sampleValid = 1'b1;
    opA = a;
    opB = b;
    scaleIn = v;
    scaleShift = s;
    expTotal += int'(a) * int'(b) + roundedScale(int'(v), int'(s));
  endtask

  task automatic idleCycles(input int n);
    repeat (n)
    begin
      @(negedge C);
      sampleValid = 1'b0;
    end
  endtask

  // compares the published block against the model, then clears the model.
  task automatic checkResult(input string what);
    accum expSum;
    logic expFlag;
    expSum = accum'(expTotal % ACC_RANGE);
    expFlag = (expTotal >= ACC_RANGE);
    checkSum(blockSum, expSum, {what, " block sum"});
    checkFlag(blockOverflow, expFlag, {what, " overflow flag"});
    expTotal = 0;
  endtask

  task automatic finishBlock(input string what);
    int waited;
    bit seen;
    waited = 0;
    seen = 1'b0;
    while (!seen && waited < DONE_TIMEOUT)
    begin
      @(negedge C);
      sampleValid = 1'b0;
      waited++;
      if (blockDone)
        seen = 1'b1;
    end
    if (!seen)
    begin
      $display("%s: blockDone did not arrive within %0d cycles", what, DONE_TIMEOUT);
      errorCount++;
      expTotal = 0;
    end
    else
      checkResult(what);
  endtask

  task automatic endTest(input string name, input int errsBefore);
    testsRun++;
    if (errorCount == errsBefore)
      $display("%s: passed", name);
    else
    begin
      testsFailed++;
      $display("%s: failed", name);
    end
  endtask

  task automatic productOnlyTest();
    int errs;
    errs = errorCount;
    for (int i = 0; i < `MAC_BLOCK_LEN; i++)
      driveSample((i == 0) ? operand'(15) : operand'(i),
                  (i == 0) ? operand'(15) : operand'((i * 7) % 16), sample'(0), shiftSel'(0));
    finishBlock("product only");
    checkFlag(blockOverflow, 1'b0, "product only overflow clear");
    endTest("test 1 product only", errs);
  endtask

  // the two blocks cover odd and even inputs under every shift.
  task automatic scaleRoundingTest();
    int errs;
    errs = errorCount;
    for (int blk = 0; blk < 2; blk++)
    begin
      for (int i = 0; i < `MAC_BLOCK_LEN; i++)
        driveSample(operand'(0), operand'(5), sample'(i * 37 + 11 + blk), shiftSel'(i));
      finishBlock("scale rounding");
    end
    endTest("test 2 scale rounding", errs);
  endtask

  task automatic overflowTest();
    int errs;
    errs = errorCount;
    for (int i = 0; i < `MAC_BLOCK_LEN; i++)
      driveSample(operand'(15), operand'(15), sample'(255), shiftSel'(0));
    finishBlock("overflow block");
    checkFlag(blockOverflow, 1'b1, "overflow set");
    for (int i = 0; i < `MAC_BLOCK_LEN; i++)
      driveSample(operand'(1), operand'(1), sample'(0), shiftSel'(0));
    finishBlock("small block after overflow");
    checkFlag(blockOverflow, 1'b0, "overflow cleared for next block");
    endTest("test 3 overflow", errs);
  endtask

  // done must show on the second falling edge after the last drive.
  task automatic gapLatencyTest();
    int errs;
    int gap;
    errs = errorCount;
    for (int i = 0; i < `MAC_BLOCK_LEN; i++)
    begin
      driveSample(operand'($random(seed)), operand'($random(seed)),
                  sample'($random(seed)), shiftSel'($random(seed)));
      gap = $random(seed) & 3;
      if (i < `MAC_BLOCK_LEN - 1)
        idleCycles(gap);
    end
    idleCycles(1);
    checkFlag(blockDone, 1'b0, "blockDone one cycle after last sample");
    @(negedge C);
    checkFlag(blockDone, 1'b1, "blockDone two cycles after last sample");
    checkResult("gaps");
    @(negedge C);
    checkFlag(blockDone, 1'b0, "blockDone pulse width");
    endTest("test 4 gaps and latency", errs);
  endtask

  task automatic midBlockResetTest();
    int errs;
    errs = errorCount;
    for (int i = 0; i < 7; i++)
      driveSample(operand'(i + 3), operand'(9), sample'(40 + i), shiftSel'(1));
    @(negedge C);
    sampleValid = 1'b0;
    CLR = 1'b1;
    idleCycles(2);
    checkFlag(blockDone, 1'b0, "blockDone during reset");
    checkSum(blockSum, accum'(0), "blockSum after reset");
    CLR = 1'b0;
    expTotal = 0;
    for (int i = 0; i < `MAC_BLOCK_LEN; i++)
      driveSample(operand'(i), operand'(2), sample'(i * 5), shiftSel'(2));
    finishBlock("block after reset");
    endTest("test 5 reset mid-block", errs);
  endtask

  initial
  begin
    CLR = 1'b1;
    sampleValid = 1'b0;
    opA = '0;
    opB = '0;
    scaleIn = '0;
    scaleShift = '0;
    repeat (8) @(negedge C);
    CLR = 1'b0;
    productOnlyTest();
    scaleRoundingTest();
    overflowTest();
    gapLatencyTest();
    midBlockResetTest();
    $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errorCount);
    if (errorCount == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* tb.f */
+incdir+.
arithPkg.sv
blockPkg.sv
arrayMult4.sv
shiftScaler.sv
claAdder.sv
blockAccum.sv
macTop.sv
tb_macTop.sv

/* run.sh */
#!/bin/sh
# Build the block multiply-accumulate testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --top-module tb_macTop -f tb.f -o simv > build.log 2>&1 \
  && ./obj_dir/simv > sim.log 2>&1 \
  || echo "build or simulation did not complete, see build.log and sim.log"

grep -q "ALL TESTS PASSED" sim.log 2>/dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
